//--- wisc_core.f
+incdir+include
verilog/wisc_pkg.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/wisc_core.sv
test/wisc_core_tb.sv

//--- Makefile
# Verilator build and run for the WISC core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := wisc_core_tb
FILELIST  := wisc_core.f
BUILD_DIR := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/wisc_core_tb.sv
// Testbench for the WISC core with a random program, reference model and watchdog
`timescale 1ns/1ps
`include "wisc_defines.svh"

module wisc_core_tb;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 8;
	localparam int PROG_LEN     = 200;
	localparam int HALT_IDX     = PROG_LEN - 1;
	// Fetch to write-back distance in cycles
	localparam int PIPE_DEPTH   = 4;
	localparam int WATCHDOG_NS  = (PROG_LEN + RESET_CYCLES + 20) * CLK_PERIOD;
	localparam logic [15:0] NOP_WORD = {`WISC_OP_NOP, 11'b0};
	// Four registers only, so dependencies are dense
	localparam logic [11:0] REG_POOL = {3'd6, 3'd5, 3'd2, 3'd1};

	logic                    clk;
	logic                    rst_n;
	logic [`WISC_DATA_W-1:0] imem_addr;
	logic [`WISC_DATA_W-1:0] imem_data;
	wisc_pkg::wb_t           wb;
	logic                    halted;

	logic [`WISC_DATA_W-1:0] prog [PROG_LEN];
	wisc_pkg::wb_t           exp_q [$];
	int                      exp_cyc_q [$];
	string                   exp_name_q [$];
	int                      cyc;
	int                      checks;
	int                      mismatches;
	int                      other_errs;

	wisc_core wisc_core_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb        (wb),
		.halted    (halted)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// Instruction memory, one word per two bytes, NOP past the end
	assign imem_data = (imem_addr[15:1] < 15'(PROG_LEN)) ? prog[imem_addr[8:1]] : NOP_WORD;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [2:0] pool_reg(input logic [1:0] sel);
		return REG_POOL[int'(sel) * 3 +: 3];
	endfunction

	// Builds the program and runs it in order, queuing every register write
	task automatic build_program();
		logic [31:0]   rng;
		logic [15:0]   regs [8];
		logic [2:0]    rs;
		logic [2:0]    rt;
		logic [2:0]    rd;
		logic [2:0]    dest;
		logic [4:0]    imm5;
		logic [7:0]    imm8;
		logic [15:0]   a;
		logic [15:0]   b;
		logic [15:0]   res;
		int            kind;
		string         name;
		wisc_pkg::wb_t rec;
		rng = 32'he67a_d9d6;
		for (int r = 0; r < 8; r++) begin
			regs[r] = '0;
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			rng = xorshift32(rng);
			// First write lands at a known cycle, HALT ends the program
			kind = (i == 0) ? 8 : (i == HALT_IDX) ? 11 : int'(rng % 32'd11);
			rng = xorshift32(rng);
			rs = pool_reg(rng[1:0]);
			rt = pool_reg(rng[3:2]);
			rd = pool_reg(rng[5:4]);
			imm8 = rng[15:8];
			imm5 = rng[20:16];
			a = regs[rs];
			b = regs[rt];
			res = '0;
			case (kind)
				0: begin
					name = "add";
					prog[i] = {`WISC_OP_ALU, rs, rt, rd, `WISC_FUNC_ADD};
					res = a + b;
				end
				1: begin
					name = "sub";
					prog[i] = {`WISC_OP_ALU, rs, rt, rd, `WISC_FUNC_SUB};
					res = b - a;
				end
				2: begin
					name = "xor";
					prog[i] = {`WISC_OP_ALU, rs, rt, rd, `WISC_FUNC_XOR};
					res = a ^ b;
				end
				3: begin
					name = "andn";
					prog[i] = {`WISC_OP_ALU, rs, rt, rd, `WISC_FUNC_ANDN};
					res = a & ~b;
				end
				4: begin
					name = "addi";
					prog[i] = {`WISC_OP_ADDI, rs, rt, imm5};
					res = a + {{11{imm5[4]}}, imm5};
				end
				5: begin
					// Immediate is the minuend
					name = "subi";
					prog[i] = {`WISC_OP_SUBI, rs, rt, imm5};
					res = {{11{imm5[4]}}, imm5} - a;
				end
				6: begin
					name = "xori";
					prog[i] = {`WISC_OP_XORI, rs, rt, imm5};
					res = a ^ {11'b0, imm5};
				end
				7: begin
					name = "andni";
					prog[i] = {`WISC_OP_ANDNI, rs, rt, imm5};
					res = a & ~{11'b0, imm5};
				end
				8: begin
					name = "lbi";
					prog[i] = {`WISC_OP_LBI, rs, imm8};
					res = {{8{imm8[7]}}, imm8};
				end
				9: begin
					name = "slbi";
					prog[i] = {`WISC_OP_SLBI, rs, imm8};
					res = (a << 8) | {8'b0, imm8};
				end
				10: begin
					name = "nop";
					prog[i] = {`WISC_OP_NOP, rng[26:16]};
				end
				default: begin
					name = "halt";
					prog[i] = {`WISC_OP_HALT, 11'b0};
				end
			endcase
			dest = (kind < 4) ? rd : (kind < 8) ? rt : rs;
			if (kind < 10) begin
				regs[dest] = res;
				rec.valid = 1'b1;
				rec.reg_sel = dest;
				rec.data = res;
				exp_q.push_back(rec);
				exp_cyc_q.push_back(i + PIPE_DEPTH);
				exp_name_q.push_back($sformatf("%s #%0d", name, i));
			end
		end
	endtask

	// Cycle c counts from the first fetch after reset
	task automatic check_cycle(input int c);
		logic                    exp_halted;
		logic [`WISC_DATA_W-1:0] exp_addr;
		exp_halted = (c >= HALT_IDX + PIPE_DEPTH);
		// PC holds once decode has seen the HALT, two cycles after its fetch
		exp_addr = `WISC_DATA_W'(`WISC_PC_STEP * ((c < HALT_IDX + 2) ? c : HALT_IDX + 2));
		checks++;
		assert (imem_addr === exp_addr) else begin
			mismatches++;
			$display("mismatch fetch address cycle %0d: expected %h actual %h",
				c, exp_addr, imem_addr);
		end
		checks++;
		assert (halted === exp_halted) else begin
			mismatches++;
			$display("mismatch halted cycle %0d: expected %0b actual %0b", c, exp_halted, halted);
		end
		if (wb.valid === 1'b1) begin
			checks++;
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("write to r%0d in cycle %0d after the last expected write", wb.reg_sel, c);
			end else begin
				assert (exp_cyc_q[0] == c) else begin
					mismatches++;
					$display("mismatch %s write cycle: expected %0d actual %0d",
						exp_name_q[0], exp_cyc_q[0], c);
				end
				assert (wb === exp_q[0]) else begin
					mismatches++;
					$display("mismatch %s: expected r%0d=%h actual r%0d=%h", exp_name_q[0],
						exp_q[0].reg_sel, exp_q[0].data, wb.reg_sel, wb.data);
				end
				void'(exp_q.pop_front());
				void'(exp_cyc_q.pop_front());
				void'(exp_name_q.pop_front());
			end
		end else if (wb.valid !== 1'b0) begin
			other_errs++;
			$display("wb.valid is unknown in cycle %0d", c);
		end else if (exp_q.size() != 0 && exp_cyc_q[0] == c) begin
			other_errs++;
			$display("write of %s did not appear in cycle %0d", exp_name_q[0], c);
		end
	endtask

	always @(posedge clk) begin
		if (rst_n === 1'b1) begin
			check_cycle(cyc);
			cyc <= cyc + 1;
		end
	end

	// Halted holds until reset and no write follows it
	halted_holds: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
		else begin
			other_errs = other_errs + 1;
			$display("halted dropped after it had risen");
		end
	no_write_halted: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !wb.valid)
		else begin
			other_errs = other_errs + 1;
			$display("register write on wb while halted");
		end

	initial begin
		rst_n = 1'b0;
		cyc = 0;
		checks = 0;
		mismatches = 0;
		other_errs = 0;
		build_program();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		while (halted !== 1'b1) begin
			@(posedge clk);
		end
		// A few cycles more to catch late writes
		repeat (6) @(posedge clk);
		checks++;
		assert (exp_q.size() == 0) else begin
			other_errs++;
			$display("%0d expected writes never appeared on wb", exp_q.size());
		end
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
		if (mismatches == 0 && other_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the core did not halt within %0d ns", WATCHDOG_NS);
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- verilog/wisc_core.sv
// Five-stage pipelined WISC core top with PC, stage registers and write-back port
`timescale 1ns/1ps
`include "wisc_defines.svh"

module wisc_core (
	input  logic                    clk,
	input  logic                    rst_n,
	output logic [`WISC_DATA_W-1:0] imem_addr,
	input  logic [`WISC_DATA_W-1:0] imem_data,
	output wisc_pkg::wb_t           wb,
	output logic                    halted
);

	// Fetch
	logic [`WISC_DATA_W-1:0] pc;
	logic                    halt_seen;

	// Fetch/decode register
	logic [`WISC_DATA_W-1:0] fd_instr;
	logic                    fd_valid;

	// Decode
	logic                    dec_valid;
	wisc_pkg::dec_ctrl_t     dec_ctrl;
	logic [`WISC_DATA_W-1:0] dec_rs_data;
	logic [`WISC_DATA_W-1:0] dec_rt_data;

	// Decode/execute register
	wisc_pkg::exe_stage_t    de_stage;

	// Execute
	wisc_pkg::wb_t           exe_result;
	logic                    exe_halt;

	// Execute/memory and memory/write-back registers
	wisc_pkg::wb_t           exm_rec;
	logic                    exm_halt;
	wisc_pkg::wb_t           mwb_rec;
	logic                    halted_q;

	// Fetch logic
	assign imem_addr = pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!halt_seen) begin
			pc <= pc + `WISC_PC_STEP;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fd_instr <= '0;
			fd_valid <= 1'b0;
		end else begin
			fd_instr <= imem_data;
			// Only the reset bubble is invalid
			fd_valid <= 1'b1;
		end
	end

	// Decode logic
	// Nothing after a decoded HALT may take effect
	assign dec_valid = fd_valid & ~halt_seen;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halt_seen <= 1'b0;
		end else if (dec_ctrl.is_halt) begin
			halt_seen <= 1'b1;
		end
	end

	instr_decode instr_decode_i (
		.instr     (fd_instr),
		.valid     (dec_valid),
		.ctrl      (dec_ctrl)
	);

	// Written from write-back, bypassed to decode reads
	reg_file reg_file_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_sel_a  (dec_ctrl.rs_sel),
		.rd_sel_b  (dec_ctrl.rt_sel),
		.rd_data_a (dec_rs_data),
		.rd_data_b (dec_rt_data),
		.wr_en     (mwb_rec.valid),
		.wr_sel    (mwb_rec.reg_sel),
		.wr_data   (mwb_rec.data)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			de_stage <= '0;
		end else begin
			de_stage.ctrl    <= dec_ctrl;
			de_stage.rs_data <= dec_rs_data;
			de_stage.rt_data <= dec_rt_data;
		end
	end

	// Execute logic
	execute_unit execute_unit_i (
		.stage     (de_stage),
		.fwd_mem   (exm_rec),
		.fwd_wb    (mwb_rec),
		.result    (exe_result),
		.is_halt   (exe_halt)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exm_rec  <= '0;
			exm_halt <= 1'b0;
		end else begin
			exm_rec  <= exe_result;
			exm_halt <= exe_halt;
		end
	end

	// Memory stage only delays the record by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mwb_rec <= '0;
		end else begin
			mwb_rec <= exm_rec;
		end
	end

	// Sticky once HALT enters write-back
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halted_q <= 1'b0;
		end else if (exm_halt) begin
			halted_q <= 1'b1;
		end
	end

	// Write-back port
	assign wb     = mwb_rec;
	assign halted = halted_q;

endmodule

//--- verilog/execute_unit.sv
// Execute stage with operand forwarding, ALU and byte-load results
`timescale 1ns/1ps
`include "wisc_defines.svh"

module execute_unit (
	input  wisc_pkg::exe_stage_t stage,
	input  wisc_pkg::wb_t        fwd_mem,
	input  wisc_pkg::wb_t        fwd_wb,
	output wisc_pkg::wb_t        result,
	output logic                 is_halt
);

	// Newest value of a source register, memory stage first
	function automatic logic [`WISC_DATA_W-1:0] fwd_pick(
		input logic [`WISC_REG_W-1:0]  sel,
		input logic [`WISC_DATA_W-1:0] rf_val,
		input wisc_pkg::wb_t           mem_rec,
		input wisc_pkg::wb_t           wb_rec
	);
		logic [`WISC_DATA_W-1:0] val;
		if (mem_rec.valid && (mem_rec.reg_sel == sel)) begin
			val = mem_rec.data;
		end else if (wb_rec.valid && (wb_rec.reg_sel == sel)) begin
			val = wb_rec.data;
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	logic [`WISC_DATA_W-1:0] op_a;
	logic [`WISC_DATA_W-1:0] rt_val;
	logic [`WISC_DATA_W-1:0] op_b;
	logic [`WISC_DATA_W-1:0] minuend;
	logic [`WISC_DATA_W-1:0] alu_out;
	logic [`WISC_DATA_W-1:0] slbi_out;

	assign op_a   = fwd_pick(stage.ctrl.rs_sel, stage.rs_data, fwd_mem, fwd_wb);
	assign rt_val = fwd_pick(stage.ctrl.rt_sel, stage.rt_data, fwd_mem, fwd_wb);
	assign op_b   = stage.ctrl.use_imm ? stage.ctrl.imm : rt_val;

	// SUBI subtracts Rs from the immediate, SUB from Rt
	assign minuend = stage.ctrl.reverse_sub ? stage.ctrl.imm : rt_val;

	always_comb begin
		case (stage.ctrl.alu_op)
			wisc_pkg::ALU_ADD:  alu_out = op_a + op_b;
			wisc_pkg::ALU_SUB:  alu_out = minuend - op_a;
			wisc_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
			wisc_pkg::ALU_ANDN: alu_out = op_a & ~op_b;
			default:            alu_out = op_a + op_b;
		endcase
	end

	// Old Rs moves up a byte, immediate fills the low byte
	assign slbi_out = (op_a << 8) | stage.ctrl.imm;

	always_comb begin
		result.valid   = stage.ctrl.write_en;
		result.reg_sel = stage.ctrl.write_reg;
		if (stage.ctrl.is_lbi) begin
			result.data = stage.ctrl.imm;
		end else if (stage.ctrl.is_slbi) begin
			result.data = slbi_out;
		end else begin
			result.data = alu_out;
		end
	end

	assign is_halt = stage.ctrl.is_halt;

endmodule

//--- verilog/reg_file.sv
// Eight-entry register file with two read ports and write-to-read bypass
`timescale 1ns/1ps
`include "wisc_defines.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`WISC_REG_W-1:0]  rd_sel_a,
	input  logic [`WISC_REG_W-1:0]  rd_sel_b,
	output logic [`WISC_DATA_W-1:0] rd_data_a,
	output logic [`WISC_DATA_W-1:0] rd_data_b,
	input  logic                    wr_en,
	input  logic [`WISC_REG_W-1:0]  wr_sel,
	input  logic [`WISC_DATA_W-1:0] wr_data
);

	logic [`WISC_DATA_W-1:0] regs [`WISC_REG_CNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `WISC_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// New data wins over the stored value in the write cycle
	assign rd_data_a = (wr_en && (wr_sel == rd_sel_a)) ? wr_data : regs[rd_sel_a];
	assign rd_data_b = (wr_en && (wr_sel == rd_sel_b)) ? wr_data : regs[rd_sel_b];

endmodule

//--- verilog/instr_decode.sv
// Instruction decoder producing control fields, register selects and the immediate
`timescale 1ns/1ps
`include "wisc_defines.svh"

module instr_decode (
	input  logic [`WISC_DATA_W-1:0] instr,
	input  logic                    valid,
	output wisc_pkg::dec_ctrl_t     ctrl
);

	logic [4:0]             opcode;
	logic [1:0]             funct;
	logic [`WISC_REG_W-1:0] rs;
	logic [`WISC_REG_W-1:0] rt;
	logic [`WISC_REG_W-1:0] rd;
	logic [4:0]             imm5;
	logic [7:0]             imm8;

	// Instruction fields
	assign opcode = instr[15:11];
	assign rs     = instr[10:8];
	assign rt     = instr[7:5];
	assign rd     = instr[4:2];
	assign funct  = instr[1:0];
	assign imm5   = instr[4:0];
	assign imm8   = instr[7:0];

	always_comb begin
		// Defaults describe a non-writing instruction
		ctrl             = '0;
		ctrl.alu_op      = wisc_pkg::ALU_ADD;
		ctrl.rs_sel      = rs;
		ctrl.rt_sel      = rt;
		ctrl.write_reg   = rd;

		case (opcode)
			`WISC_OP_ALU: begin
				ctrl.alu_op   = wisc_pkg::alu_op_e'(funct);
				ctrl.write_en = 1'b1;
			end
			`WISC_OP_ADDI,
			`WISC_OP_SUBI: begin
				// Low opcode bits follow the function encoding
				ctrl.alu_op      = wisc_pkg::alu_op_e'(opcode[1:0]);
				ctrl.use_imm     = 1'b1;
				ctrl.reverse_sub = (opcode == `WISC_OP_SUBI);
				ctrl.write_en    = 1'b1;
				ctrl.write_reg   = rt;
				ctrl.imm         = {{(`WISC_DATA_W-5){imm5[4]}}, imm5};
			end
			`WISC_OP_XORI,
			`WISC_OP_ANDNI: begin
				ctrl.alu_op    = wisc_pkg::alu_op_e'(opcode[1:0]);
				ctrl.use_imm   = 1'b1;
				ctrl.write_en  = 1'b1;
				ctrl.write_reg = rt;
				ctrl.imm       = {{(`WISC_DATA_W-5){1'b0}}, imm5};
			end
			`WISC_OP_LBI: begin
				ctrl.is_lbi    = 1'b1;
				ctrl.write_en  = 1'b1;
				ctrl.write_reg = rs;
				ctrl.imm       = {{(`WISC_DATA_W-8){imm8[7]}}, imm8};
			end
			`WISC_OP_SLBI: begin
				// Rs is both source and destination
				ctrl.is_slbi   = 1'b1;
				ctrl.write_en  = 1'b1;
				ctrl.write_reg = rs;
				ctrl.imm       = {{(`WISC_DATA_W-8){1'b0}}, imm8};
			end
			`WISC_OP_HALT: begin
				ctrl.is_halt = 1'b1;
			end
			`WISC_OP_NOP: begin
				ctrl.write_en = 1'b0;
			end
			default: begin
				// Unknown opcode behaves as a NOP
				ctrl.write_en = 1'b0;
			end
		endcase

		// Bubbles and squashed slots do nothing
		if (!valid) begin
			ctrl.write_en = 1'b0;
			ctrl.is_halt  = 1'b0;
		end
	end

endmodule

//--- verilog/wisc_pkg.sv
// Types carried between the pipeline stages of the WISC core
`include "wisc_defines.svh"

package wisc_pkg;

	// Encoded to match the function field
	typedef enum logic [1:0] {
		ALU_ADD  = `WISC_FUNC_ADD,
		ALU_SUB  = `WISC_FUNC_SUB,
		ALU_XOR  = `WISC_FUNC_XOR,
		ALU_ANDN = `WISC_FUNC_ANDN
	} alu_op_e;

	// Decoded controls of one instruction
	typedef struct packed {
		alu_op_e                 alu_op;
		logic                    use_imm;
		// Immediate is the minuend
		logic                    reverse_sub;
		logic                    is_lbi;
		logic                    is_slbi;
		logic                    write_en;
		logic [`WISC_REG_W-1:0]  write_reg;
		logic                    is_halt;
		logic [`WISC_REG_W-1:0]  rs_sel;
		logic [`WISC_REG_W-1:0]  rt_sel;
		logic [`WISC_DATA_W-1:0] imm;
	} dec_ctrl_t;

	// Decode to execute payload
	typedef struct packed {
		dec_ctrl_t               ctrl;
		logic [`WISC_DATA_W-1:0] rs_data;
		logic [`WISC_DATA_W-1:0] rt_data;
	} exe_stage_t;

	// Register write record, also used for forwarding
	typedef struct packed {
		logic                    valid;
		logic [`WISC_REG_W-1:0]  reg_sel;
		logic [`WISC_DATA_W-1:0] data;
	} wb_t;

endpackage

//--- include/wisc_defines.svh
// Widths, register count, PC step and instruction encodings of the WISC core
`ifndef WISC_DEFINES_SVH
`define WISC_DEFINES_SVH

// Datapath and register file sizes
`define WISC_DATA_W   16
`define WISC_REG_CNT  8
`define WISC_REG_W    3
`define WISC_PC_STEP  2

// Opcodes in instr[15:11]
`define WISC_OP_HALT  5'b00000
`define WISC_OP_NOP   5'b00001
`define WISC_OP_ADDI  5'b01000
`define WISC_OP_SUBI  5'b01001
`define WISC_OP_XORI  5'b01010
`define WISC_OP_ANDNI 5'b01011
`define WISC_OP_SLBI  5'b10010
`define WISC_OP_LBI   5'b11000
`define WISC_OP_ALU   5'b11011

// Function field of register ALU ops, instr[1:0]
`define WISC_FUNC_ADD  2'b00
`define WISC_FUNC_SUB  2'b01
`define WISC_FUNC_XOR  2'b10
`define WISC_FUNC_ANDN 2'b11

`endif
